//--- hdl/raster_defs.svh
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Triangle store geometry
`define TRI_SLOTS 16
`define TRI_ADDR_W 4

// Host write queue, which also sets how many write credits the host starts with
`define WR_QUEUE_DEPTH 4

// Feeder prefetch queue between store reads and the output register
`define FETCH_DEPTH 4

// Input slots on the rasterizer side
`define OUT_CREDITS 2

`endif

//--- hdl/vertex_pkg.sv
`default_nettype none

`include "raster_defs.svh"

package vertex_pkg;

    // Signed Q16.16 screen coordinate
    typedef logic signed [31:0] q16_16_t;

    // RGB 4:4:4
    typedef logic [11:0] color_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t  pos;
        color_t color;
    } vertex_t;  // 108 bits

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;  // 324 bits

    typedef logic [`TRI_ADDR_W-1:0] tri_addr_t;

    // One host write as it sits in the writer queue
    typedef struct packed {
        tri_addr_t addr;
        triangle_t tri_data;
    } tri_write_t;

endpackage

`default_nettype wire

//--- hdl/sync_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   push,
    input  wire T                       push_data,
    input  wire logic                   pop,
    output T                            head,
    output logic                        empty,
    output logic                        full,
    output logic [$clog2(DEPTH+1)-1:0]  count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Pointers wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];  // Fall-through read of the oldest entry
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("sync_fifo push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("sync_fifo pop while empty");

endmodule

`default_nettype wire

//--- hdl/tri_store.sv
`default_nettype none
`timescale 1ns/10ps

`include "raster_defs.svh"

module tri_store (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_req,
    input  wire vertex_pkg::tri_addr_t wr_addr,
    input  wire vertex_pkg::triangle_t wr_data,
    output logic                       wr_gnt,
    input  wire logic                  rd_req,
    input  wire vertex_pkg::tri_addr_t rd_addr,
    output logic                       rd_gnt,
    output logic                       rd_rvalid,
    output vertex_pkg::triangle_t      rd_data
);

    import vertex_pkg::*;

    triangle_t mem [`TRI_SLOTS];
    logic      last_wr;  // High when the write port won the most recent grant

    // One access per cycle; on a tie the port that lost last time goes first
    assign wr_gnt = wr_req && (!rd_req || !last_wr);
    assign rd_gnt = rd_req && (!wr_req || last_wr);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_wr <= 1'b0;
        end else if (wr_gnt) begin
            last_wr <= 1'b1;
        end else if (rd_gnt) begin
            last_wr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_gnt) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (rd_gnt) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_rvalid <= 1'b0;
        end else begin
            rd_rvalid <= rd_gnt;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst) !(wr_gnt && rd_gnt))
        else $error("tri_store granted both ports in one cycle");

    // Two contended cycles in a row must alternate the winner
    a_round_robin: assert property (@(posedge clk) disable iff (rst)
        (wr_req && rd_req) ##1 (wr_req && rd_req) |-> (wr_gnt != $past(wr_gnt)))
        else $error("tri_store arbiter failed to alternate under contention");

endmodule

`default_nettype wire

//--- hdl/scene_writer.sv
`default_nettype none
`timescale 1ns/10ps

`include "raster_defs.svh"

module scene_writer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  host_valid,
    input  wire vertex_pkg::tri_addr_t host_addr,
    input  wire vertex_pkg::triangle_t host_tri,
    output logic                       host_credit,
    output logic                       mem_req,
    output vertex_pkg::tri_addr_t      mem_addr,
    output vertex_pkg::triangle_t      mem_data,
    input  wire logic                  mem_gnt
);

    import vertex_pkg::*;

    localparam int CNT_W = $clog2(`WR_QUEUE_DEPTH + 1);

    tri_write_t       q_in;
    tri_write_t       q_head;
    logic             q_empty;
    logic [CNT_W-1:0] q_count;

    assign q_in.addr     = host_addr;
    assign q_in.tri_data = host_tri;

    sync_fifo #(
        .T     (tri_write_t),
        .DEPTH (`WR_QUEUE_DEPTH)
    ) u_wr_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (host_valid),
        .push_data (q_in),
        .pop       (mem_gnt),
        .head      (q_head),
        .empty     (q_empty),
        .full      (),
        .count     (q_count)
    );

    assign mem_req  = !q_empty;  // Head stays on the store port until granted
    assign mem_addr = q_head.addr;
    assign mem_data = q_head.tri_data;

    // Each drained entry frees one slot, so it hands one credit back
    always_ff @(posedge clk) begin
        if (rst) begin
            host_credit <= 1'b0;
        end else begin
            host_credit <= mem_gnt;
        end
    end

    // A host that honours its credits never finds the queue full
    a_host_credit: assert property (@(posedge clk) disable iff (rst)
        host_valid |-> (q_count < `WR_QUEUE_DEPTH))
        else $error("scene_writer host wrote without a credit");

endmodule

`default_nettype wire

//--- hdl/triangle_feeder.sv
`default_nettype none
`timescale 1ns/10ps

`include "raster_defs.svh"

module triangle_feeder (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  begin_frame,
    input  wire logic [`TRI_ADDR_W:0]  frame_tris,
    input  wire vertex_pkg::q16_16_t   offset_x,
    input  wire vertex_pkg::q16_16_t   offset_y,
    output logic                       mem_req,
    output vertex_pkg::tri_addr_t      mem_addr,
    input  wire logic                  mem_gnt,
    input  wire logic                  mem_rvalid,
    input  wire vertex_pkg::triangle_t mem_data,
    output logic                       out_valid,
    output vertex_pkg::triangle_t      out_tri,
    input  wire logic                  out_credit,
    output logic                       busy
);

    import vertex_pkg::*;

    localparam int LVL_W = $clog2(`FETCH_DEPTH + 1);
    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

    logic [`TRI_ADDR_W:0] frame_len;
    q16_16_t              off_x;
    q16_16_t              off_y;
    logic [`TRI_ADDR_W:0] rd_idx;    // Next slot to read
    logic [`TRI_ADDR_W:0] sent_cnt;
    logic [LVL_W-1:0]     inflight;  // Granted reads whose data has not returned
    logic [CRD_W-1:0]     credits;

    triangle_t        shifted;
    triangle_t        q_head;
    logic             q_empty;
    logic [LVL_W-1:0] q_count;
    logic             send;

    function automatic vertex_t shift_vertex(input vertex_t v, input q16_16_t dx,
                                             input q16_16_t dy);
        vertex_t r;
        r       = v;
        r.pos.x = v.pos.x + dx;  // Wraps modulo 2^32
        r.pos.y = v.pos.y + dy;
        return r;
    endfunction

    always_comb begin
        shifted.v0 = shift_vertex(mem_data.v0, off_x, off_y);
        shifted.v1 = shift_vertex(mem_data.v1, off_x, off_y);
        shifted.v2 = shift_vertex(mem_data.v2, off_x, off_y);
    end

    // Reserve a queue slot for every read before it is issued
    assign mem_req  = busy && (rd_idx < frame_len) && ((inflight + q_count) < `FETCH_DEPTH);
    assign mem_addr = rd_idx[`TRI_ADDR_W-1:0];
    assign send     = !q_empty && (credits != '0);

    sync_fifo #(
        .T     (triangle_t),
        .DEPTH (`FETCH_DEPTH)
    ) u_fetch_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (mem_rvalid),
        .push_data (shifted),
        .pop       (send),
        .head      (q_head),
        .empty     (q_empty),
        .full      (),
        .count     (q_count)
    );

    always_ff @(posedge clk) begin
        if (begin_frame && !busy) begin
            frame_len <= frame_tris;
            off_x     <= offset_x;
            off_y     <= offset_y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            rd_idx   <= '0;
            sent_cnt <= '0;
        end else if (!busy) begin
            if (begin_frame) begin
                busy     <= 1'b1;
                rd_idx   <= '0;
                sent_cnt <= '0;
            end
        end else begin
            if (mem_gnt) rd_idx <= rd_idx + 1'b1;
            if (send) sent_cnt <= sent_cnt + 1'b1;
            if (sent_cnt == frame_len) busy <= 1'b0;  // Last one is on out_valid now
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
        end else begin
            case ({mem_gnt, mem_rvalid})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRD_W'(`OUT_CREDITS);
        end else begin
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_tri <= q_head;
        end
    end

    // The rasterizer must not return more credits than it has slots
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= `OUT_CREDITS)
        else $error("triangle_feeder credit count above the rasterizer slot count");

    a_send_with_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> ($past(credits) != '0))
        else $error("triangle_feeder sent a triangle without a credit");

endmodule

`default_nettype wire

//--- hdl/tri_frontend.sv
`default_nettype none
`timescale 1ns/10ps

`include "raster_defs.svh"

module tri_frontend (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  wr_valid,
    input  wire vertex_pkg::tri_addr_t wr_addr,
    input  wire vertex_pkg::triangle_t wr_tri,
    output logic                       wr_credit,
    input  wire logic                  begin_frame,
    input  wire logic [`TRI_ADDR_W:0]  frame_tris,
    input  wire vertex_pkg::q16_16_t   offset_x,
    input  wire vertex_pkg::q16_16_t   offset_y,
    output logic                       out_valid,
    output vertex_pkg::triangle_t      out_tri,
    input  wire logic                  out_credit,
    output logic                       busy
);

    import vertex_pkg::*;

    // Writer side of the store
    logic      st_wr_req;
    tri_addr_t st_wr_addr;
    triangle_t st_wr_data;
    logic      st_wr_gnt;

    // Feeder side of the store
    logic      st_rd_req;
    tri_addr_t st_rd_addr;
    logic      st_rd_gnt;
    logic      st_rd_rvalid;
    triangle_t st_rd_data;

    scene_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .host_valid  (wr_valid),
        .host_addr   (wr_addr),
        .host_tri    (wr_tri),
        .host_credit (wr_credit),
        .mem_req     (st_wr_req),
        .mem_addr    (st_wr_addr),
        .mem_data    (st_wr_data),
        .mem_gnt     (st_wr_gnt)
    );

    triangle_feeder u_feeder (
        .clk         (clk),
        .rst         (rst),
        .begin_frame (begin_frame),
        .frame_tris  (frame_tris),
        .offset_x    (offset_x),
        .offset_y    (offset_y),
        .mem_req     (st_rd_req),
        .mem_addr    (st_rd_addr),
        .mem_gnt     (st_rd_gnt),
        .mem_rvalid  (st_rd_rvalid),
        .mem_data    (st_rd_data),
        .out_valid   (out_valid),
        .out_tri     (out_tri),
        .out_credit  (out_credit),
        .busy        (busy)
    );

    tri_store u_store (
        .clk       (clk),
        .rst       (rst),
        .wr_req    (st_wr_req),
        .wr_addr   (st_wr_addr),
        .wr_data   (st_wr_data),
        .wr_gnt    (st_wr_gnt),
        .rd_req    (st_rd_req),
        .rd_addr   (st_rd_addr),
        .rd_gnt    (st_rd_gnt),
        .rd_rvalid (st_rd_rvalid),
        .rd_data   (st_rd_data)
    );

endmodule

`default_nettype wire

//--- test/tri_frontend_tests.svh
`ifndef TRI_FRONTEND_TESTS_SVH
`define TRI_FRONTEND_TESTS_SVH

// Every slot gets a random triangle, then one frame reads them back untouched
task automatic test_load_and_read();
    for (int s = 0; s < `TRI_SLOTS; s++) begin
        write_tri(tri_addr_t'(s), random_tri());
    end
    wait_writes_drained();
    start_frame(`TRI_SLOTS, '0, '0);
    check_frame("load_and_read", `TRI_SLOTS, '0, '0);
endtask

task automatic test_offsets();
    start_frame(`TRI_SLOTS, 32'hFFFB_0000, 32'h7FFF_8000);  // Minus 5.0 and a large positive y
    check_frame("offsets negative", `TRI_SLOTS, 32'hFFFB_0000, 32'h7FFF_8000);
    start_frame(`TRI_SLOTS, 32'h8000_0000, 32'hFFFF_FFFF);
    check_frame("offsets wrap", `TRI_SLOTS, 32'h8000_0000, 32'hFFFF_FFFF);
endtask

task automatic test_backpressure();
    credit_delay    = 10;
    max_outstanding = 0;
    start_frame(`TRI_SLOTS, 32'h0001_0000, 32'hFFFF_0000);
    check_frame("backpressure", `TRI_SLOTS, 32'h0001_0000, 32'hFFFF_0000);
    check_value("backpressure max outstanding", `OUT_CREDITS, max_outstanding);
    while (credit_due.size() > 0) begin
        step(1);
    end
    credit_delay = 1;
endtask

// Writes land in slots 8 to 15 while a frame reads slots 0 to 7
task automatic test_write_credits();
    int pulses_before;
    int writes_before;
    pulses_before = credit_pulses;
    writes_before = writes_total;
    start_frame(8, 32'h0002_0000, '0);
    for (int s = 8; s < `TRI_SLOTS; s++) begin
        write_tri(tri_addr_t'(s), random_tri());
    end
    check_frame("write_credits frame", 8, 32'h0002_0000, '0);
    wait_writes_drained();
    step(2);
    check_value("write_credits pulses", writes_total - writes_before,
                credit_pulses - pulses_before);
    check_value("write_credits host credits", `WR_QUEUE_DEPTH, host_credits);
    start_frame(`TRI_SLOTS, '0, 32'h0003_0000);
    check_frame("write_credits new", `TRI_SLOTS, '0, 32'h0003_0000);
endtask

task automatic test_busy_frames();
    start_frame(6, 32'h0000_8000, 32'h0000_4000);
    step(2);
    check_value("busy_frames busy", 1, busy);
    start_frame(`TRI_SLOTS, 32'h1111_0000, 32'h2222_0000);  // Ignored because the feeder is busy
    check_frame("busy_frames first", 6, 32'h0000_8000, 32'h0000_4000);
    check_value("busy_frames idle", 0, busy);
    start_frame(3, '0, 32'hFFFF_FFFF);
    check_frame("busy_frames second", 3, '0, 32'hFFFF_FFFF);
endtask

`endif

//--- test/tb_tri_frontend.sv
`default_nettype none
`timescale 1ns/10ps

`include "raster_defs.svh"

module tb_tri_frontend;

    import vertex_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;  // Ample for the five tests even at slow credit pacing

    logic                 clk;
    logic                 rst;
    logic                 wr_valid;
    tri_addr_t            wr_addr;
    triangle_t            wr_tri;
    logic                 wr_credit;
    logic                 begin_frame;
    logic [`TRI_ADDR_W:0] frame_tris;
    q16_16_t              offset_x;
    q16_16_t              offset_y;
    logic                 out_valid;
    triangle_t            out_tri;
    logic                 out_credit;
    logic                 busy;

    int        cycle;
    int        errors;
    int        host_credits;  // Write credits the host model holds
    int        writes_total;
    int        credit_pulses;
    int        outstanding;   // Triangles received whose credit has not gone back yet
    int        max_outstanding;
    int        credit_delay;
    triangle_t ref_mem [`TRI_SLOTS];
    triangle_t rx_q [$];
    int        credit_due [$];

    tri_frontend DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst) begin
            host_credits <= `WR_QUEUE_DEPTH;
        end else begin
            host_credits  <= host_credits + int'(wr_credit) - int'(wr_valid);
            credit_pulses <= credit_pulses + int'(wr_credit);
            writes_total  <= writes_total + int'(wr_valid);
        end
    end

    // Rasterizer model takes every triangle and schedules its credit
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                rx_q.push_back(out_tri);
                credit_due.push_back(cycle + credit_delay);
                outstanding = outstanding + 1;
                if (!busy) begin
                    $display("Error: a triangle arrived after busy fell at cycle %0d", cycle);
                    errors++;
                end
            end
            if (out_credit) outstanding = outstanding - 1;
            if (outstanding > max_outstanding) max_outstanding = outstanding;
            if (outstanding > `OUT_CREDITS) begin
                $display("Error: %0d triangles outstanding at cycle %0d, more than %0d slots",
                         outstanding, cycle, `OUT_CREDITS);
                errors++;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                out_credit = 1'b1;
            end
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the tests did not finish", cycle);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(input string test, input logic [323:0] expected,
                               input logic [323:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", test, expected, actual);
            errors++;
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic triangle_t random_tri();
        logic [351:0] bits;
        for (int i = 0; i < 11; i++) begin
            bits[i*32 +: 32] = $urandom();
        end
        return triangle_t'(bits[323:0]);
    endfunction

    // Vertex v sits at bit 108*v; x is at offset 76 and y at offset 44 within it
    function automatic triangle_t expected_tri(input triangle_t t, input q16_16_t ox,
                                               input q16_16_t oy);
        logic [323:0] r;
        r = t;
        for (int v = 0; v < 3; v++) begin
            r[v*108+76 +: 32] = r[v*108+76 +: 32] + ox;  // 32-bit add that wraps
            r[v*108+44 +: 32] = r[v*108+44 +: 32] + oy;
        end
        return triangle_t'(r);
    endfunction

    task automatic write_tri(input tri_addr_t addr, input triangle_t t);
        while (host_credits == 0) begin
            step(1);
        end
        wr_valid      = 1'b1;
        wr_addr       = addr;
        wr_tri        = t;
        ref_mem[addr] = t;
        step(1);
        wr_valid = 1'b0;
    endtask

    task automatic wait_writes_drained();
        while (host_credits != `WR_QUEUE_DEPTH) begin
            step(1);
        end
    endtask

    task automatic start_frame(input int n, input q16_16_t ox, input q16_16_t oy);
        begin_frame = 1'b1;
        frame_tris  = n[`TRI_ADDR_W:0];
        offset_x    = ox;
        offset_y    = oy;
        step(1);
        begin_frame = 1'b0;
    endtask

    // Waits for busy to fall, then expects slots 0 to n-1 in order with the offsets applied
    task automatic check_frame(input string test, input int n, input q16_16_t ox,
                               input q16_16_t oy);
        int waited;
        waited = 0;
        while (busy && waited < 1000) begin
            step(1);
            waited++;
        end
        if (busy) begin
            $display("Error in %s: busy stayed high for %0d cycles", test, waited);
            errors++;
        end
        step(4);  // Room for a stray extra triangle to show up
        check_value({test, " count"}, n, rx_q.size());
        for (int i = 0; i < n && rx_q.size() > 0; i++) begin
            check_value($sformatf("%s slot %0d", test, i), expected_tri(ref_mem[i], ox, oy),
                        rx_q.pop_front());
        end
        rx_q.delete();
    endtask

    `include "tri_frontend_tests.svh"

    initial begin
        void'($urandom(34218));
        cycle           = 0;
        errors          = 0;
        writes_total    = 0;
        credit_pulses   = 0;
        outstanding     = 0;
        max_outstanding = 0;
        credit_delay    = 1;
        rst             = 1'b1;
        wr_valid        = 1'b0;
        wr_addr         = '0;
        wr_tri          = '0;
        begin_frame     = 1'b0;
        frame_tris      = '0;
        offset_x        = '0;
        offset_y        = '0;
        out_credit      = 1'b0;
        step(4);
        rst = 1'b0;
        test_load_and_read();
        test_offsets();
        test_backpressure();
        test_write_credits();
        test_busy_frames();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
+incdir+test
hdl/vertex_pkg.sv
hdl/sync_fifo.sv
hdl/tri_store.sv
hdl/scene_writer.sv
hdl/triangle_feeder.sv
hdl/tri_frontend.sv
test/tb_tri_frontend.sv

//--- Bender.yml
package:
  name: tri_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vertex_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/tri_store.sv
      - hdl/scene_writer.sv
      - hdl/triangle_feeder.sv
      - hdl/tri_frontend.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_tri_frontend.sv
